//--- filelist.f
rtl/audio_pkg.sv
rtl/audio_regs.sv
rtl/audio_channel.sv
rtl/dma_arbiter.sv
rtl/audio_mixer.sv
rtl/audio_controller.sv
tests/tb_clock.sv
tests/tb_audio_controller.sv

//--- rtl/audio_channel.sv
`timescale 1ns/1ps

module audio_channel (
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::channel_setup_t i_setup,
	input logic i_start,
	output logic o_busy,

	// DMA request towards the arbiter
	output audio_pkg::dma_req_t o_dma,
	input logic i_grant,
	input audio_pkg::dma_word_u i_dma_rdata,

	// Frames towards the mixer
	output audio_pkg::sample_frame_t o_frame,
	output logic o_frame_valid,
	input logic i_credit
);

	import audio_pkg::*;

	logic busy;
	logic req;
	logic word_full;
	logic second_half;
	logic mono;
	logic start;
	logic send;
	logic last_frame;
	logic [31:0] next_addr;
	logic [30:0] remaining;
	logic [CREDIT_WIDTH-1:0] credits;
	logic [15:0] mono_sample;
	dma_word_u word;

	assign start = i_start && !busy;

	// A frame goes out whenever one is held and the mixer has room for it
	assign send = word_full && credits != '0;
	assign last_frame = !mono || second_half;

	always_comb begin
		mono_sample = word.mono[second_half];
		if (mono) begin
			o_frame.left = mono_sample;
			o_frame.right = mono_sample;
		end else begin
			o_frame = word.stereo;
		end
		o_frame_valid = send;
		o_dma.request = req;
		o_dma.address = next_addr;
		o_busy = busy;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			req <= 1'b0;
			word_full <= 1'b0;
			second_half <= 1'b0;
			remaining <= '0;
			credits <= CREDIT_WIDTH'(FRAME_CREDITS);
		end else begin
			credits <= credits + CREDIT_WIDTH'(i_credit) - CREDIT_WIDTH'(send);

			if (start) begin
				busy <= 1'b1;
				remaining <= i_setup.count;
			end else if (busy && remaining == '0 && !word_full && !req) begin
				busy <= 1'b0;
			end

			// Fetch the next word only once the holder has drained
			if (i_grant) begin
				req <= 1'b0;
				word_full <= 1'b1;
				remaining <= remaining - 31'd1;
			end else if (busy && remaining != '0 && !word_full && !req) begin
				req <= 1'b1;
			end

			if (send) begin
				second_half <= mono && !second_half;
				if (last_frame) begin
					word_full <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			next_addr <= i_setup.address;
			mono <= i_setup.mono;
		end else if (i_grant) begin
			// Byte address, one 32-bit word per fetch
			next_addr <= next_addr + 32'd4;
		end
		if (i_grant) begin
			word <= i_dma_rdata;
		end
	end

endmodule

//--- rtl/audio_controller.sv
`timescale 1ns/1ps

module audio_controller (
	input logic i_clock,
	input logic i_reset,

	// CPU register window
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_address,
	input logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,

	// DMA bus master
	output logic o_dma_request,
	output logic [31:0] o_dma_address,
	input logic i_dma_ready,
	input logic [31:0] i_dma_rdata,

	// Audio output
	input logic i_sample_tick,
	output logic [31:0] o_sample_rate,
	output logic signed [15:0] o_left,
	output logic signed [15:0] o_right
);

	import audio_pkg::*;

	channel_setup_t [NUM_CHANNELS-1:0] setup;
	dma_req_t [NUM_CHANNELS-1:0] dma_req;
	sample_frame_t [NUM_CHANNELS-1:0] frame;
	logic [NUM_CHANNELS-1:0] start;
	logic [NUM_CHANNELS-1:0] busy;
	logic [NUM_CHANNELS-1:0] grant;
	logic [NUM_CHANNELS-1:0] frame_valid;
	logic [NUM_CHANNELS-1:0] credit;

	audio_regs u_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_busy(busy),
		.o_setup(setup),
		.o_start(start),
		.o_sample_rate(o_sample_rate)
	);

	// Both channels see the same bus data and pick it up on their own grant
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_reset(i_reset),
			.i_setup(setup[ch]),
			.i_start(start[ch]),
			.o_busy(busy[ch]),
			.o_dma(dma_req[ch]),
			.i_grant(grant[ch]),
			.i_dma_rdata(i_dma_rdata),
			.o_frame(frame[ch]),
			.o_frame_valid(frame_valid[ch]),
			.i_credit(credit[ch])
		);
	end

	dma_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(dma_req),
		.o_grant(grant),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_frame(frame),
		.i_frame_valid(frame_valid),
		.o_credit(credit),
		.i_sample_tick(i_sample_tick),
		.o_left(o_left),
		.o_right(o_right)
	);

endmodule

//--- rtl/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::sample_frame_t [audio_pkg::NUM_CHANNELS-1:0] i_frame,
	input logic [audio_pkg::NUM_CHANNELS-1:0] i_frame_valid,
	output logic [audio_pkg::NUM_CHANNELS-1:0] o_credit,

	input logic i_sample_tick,
	output logic signed [15:0] o_left,
	output logic signed [15:0] o_right
);

	import audio_pkg::*;

	sample_frame_t head [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] pop;
	logic signed [MIX_WIDTH-1:0] sum_left;
	logic signed [MIX_WIDTH-1:0] sum_right;

	function automatic logic signed [15:0] saturate(input logic signed [MIX_WIDTH-1:0] value);
		if (value > 32767) begin
			return 16'sh7fff;
		end else if (value < -32768) begin
			return 16'sh8000;
		end
		return value[15:0];
	endfunction

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_fifo
		sample_frame_t mem [FRAME_CREDITS];
		logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
		logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
		logic [CREDIT_WIDTH-1:0] count;

		// The channel's credits keep this FIFO from overflowing
		assign pop[ch] = i_sample_tick && count != '0;
		assign head[ch] = mem[rd_ptr];

		always_ff @(posedge i_clock) begin
			if (i_reset) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
				o_credit[ch] <= 1'b0;
			end else begin
				o_credit[ch] <= pop[ch];
				count <= count + CREDIT_WIDTH'(i_frame_valid[ch]) - CREDIT_WIDTH'(pop[ch]);
				if (i_frame_valid[ch]) begin
					wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FRAME_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
				end
				if (pop[ch]) begin
					rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FRAME_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
				end
			end
		end

		always_ff @(posedge i_clock) begin
			if (i_frame_valid[ch]) begin
				mem[wr_ptr] <= i_frame[ch];
			end
		end
	end

	// Empty channels add nothing
	always_comb begin
		sum_left = '0;
		sum_right = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (pop[ch]) begin
				sum_left = sum_left + head[ch].left;
				sum_right = sum_right + head[ch].right;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_left <= '0;
			o_right <= '0;
		end else if (i_sample_tick) begin
			o_left <= saturate(sum_left);
			o_right <= saturate(sum_right);
		end
	end

endmodule

//--- rtl/audio_pkg.sv
package audio_pkg;

	localparam int NUM_CHANNELS = 2;
	localparam int FRAME_CREDITS = 2;
	localparam int CREDIT_WIDTH = $clog2(FRAME_CREDITS + 1);
	localparam int FIFO_PTR_WIDTH = $clog2(FRAME_CREDITS);

	// Headroom for the sum of all channels before clamping
	localparam int MIX_WIDTH = 16 + $clog2(NUM_CHANNELS);

	// 100 MHz / (256 * 22050)
	localparam logic [31:0] DEFAULT_RATE_DIV = 32'd17;

	// CPU register map
	localparam logic [3:0] REG_RATE = 4'd0;
	localparam logic [3:0] REG_STATUS = 4'd1;
	localparam logic [3:0] REG_CH0_ADDR = 4'd2;
	localparam logic [3:0] REG_CH0_COUNT = 4'd3;
	localparam logic [3:0] REG_CH1_ADDR = 4'd4;
	localparam logic [3:0] REG_CH1_COUNT = 4'd5;

	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} sample_frame_t;

	// One fetched word, either a stereo frame or two mono samples
	// Mono sample 0 sits in the low half and plays first
	typedef union packed {
		sample_frame_t stereo;
		logic [1:0][15:0] mono;
	} dma_word_u;

	typedef struct packed {
		logic [31:0] address;
		logic [30:0] count;
		logic mono;
	} channel_setup_t;

	typedef struct packed {
		logic request;
		logic [31:0] address;
	} dma_req_t;

endpackage

//--- rtl/audio_regs.sv
`timescale 1ns/1ps

module audio_regs (
	input logic i_clock,
	input logic i_reset,

	// CPU register window
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_address,
	input logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic o_ready,

	input logic [audio_pkg::NUM_CHANNELS-1:0] i_busy,
	output audio_pkg::channel_setup_t [audio_pkg::NUM_CHANNELS-1:0] o_setup,
	output logic [audio_pkg::NUM_CHANNELS-1:0] o_start,
	output logic [31:0] o_sample_rate
);

	import audio_pkg::*;

	logic access;
	logic write_en;
	logic [31:0] read_data;

	// A new access is accepted only once the previous one has been released
	assign access = i_request && !o_ready;
	assign write_en = access && i_rw;

	always_comb begin
		case (i_address)
			REG_RATE: read_data = o_sample_rate;
			REG_STATUS: read_data = 32'(i_busy);
			REG_CH0_ADDR: read_data = o_setup[0].address;
			REG_CH0_COUNT: read_data = {o_setup[0].mono, o_setup[0].count};
			REG_CH1_ADDR: read_data = o_setup[1].address;
			REG_CH1_COUNT: read_data = {o_setup[1].mono, o_setup[1].count};
			default: read_data = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_start <= '0;
			o_sample_rate <= DEFAULT_RATE_DIV;
		end else begin
			o_start[0] <= write_en && i_address == REG_CH0_COUNT;
			o_start[1] <= write_en && i_address == REG_CH1_COUNT;
			if (access) begin
				o_ready <= 1'b1;
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
			if (write_en && i_address == REG_RATE) begin
				o_sample_rate <= i_wdata;
			end
		end
	end

	// Read data is captured with the handshake and held while ready is up
	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			o_rdata <= read_data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (write_en) begin
			case (i_address)
				REG_CH0_ADDR: o_setup[0].address <= i_wdata;
				REG_CH0_COUNT: begin
					o_setup[0].mono <= i_wdata[31];
					o_setup[0].count <= i_wdata[30:0];
				end
				REG_CH1_ADDR: o_setup[1].address <= i_wdata;
				REG_CH1_COUNT: begin
					o_setup[1].mono <= i_wdata[31];
					o_setup[1].count <= i_wdata[30:0];
				end
				default: ;
			endcase
		end
	end

endmodule

//--- rtl/dma_arbiter.sv
`timescale 1ns/1ps

module dma_arbiter (
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::dma_req_t [audio_pkg::NUM_CHANNELS-1:0] i_req,
	output logic [audio_pkg::NUM_CHANNELS-1:0] o_grant,

	// Shared DMA bus master
	output logic o_dma_request,
	output logic [31:0] o_dma_address,
	input logic i_dma_ready
);

	import audio_pkg::*;

	logic owner;
	logic pick;

	always_comb begin
		// The channel that did not own the last transfer goes first
		pick = owner;
		if (i_req[!owner].request) begin
			pick = !owner;
		end
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			o_grant[ch] = o_dma_request && i_dma_ready && owner == ch;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_dma_request <= 1'b0;
			// Channel 0 wins the first contest
			owner <= 1'b1;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
			end
		end else if (i_req[pick].request) begin
			o_dma_request <= 1'b1;
			owner <= pick;
		end
	end

	// Address is frozen while the bus is held
	always_ff @(posedge i_clock) begin
		if (!o_dma_request) begin
			o_dma_address <= i_req[pick].address;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the audio controller testbench
verilator --binary --timing --assert -Wno-fatal --top-module tb_audio_controller \
	-f filelist.f -o tb_audio_controller \
	&& ./obj_dir/tb_audio_controller \
	|| exit 1

//--- tests/tb_audio_controller.sv
`timescale 1ns/1ps

module tb_audio_controller;

	import audio_pkg::*;

	localparam logic [31:0] BASE [2] = '{32'h0000_1000, 32'h0004_0000};
	localparam int TICK_PERIOD = 40;
	// 6 + 8 + 16 ticks over the three runs
	localparam int TOTAL_TICKS = 30;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_TICKS * TICK_PERIOD + 200);

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic [3:0] i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic o_ready;
	logic o_dma_request;
	logic [31:0] o_dma_address;
	logic i_dma_ready;
	logic [31:0] i_dma_rdata;
	logic i_sample_tick;
	logic [31:0] o_sample_rate;
	logic signed [15:0] o_left;
	logic signed [15:0] o_right;

	int cfg_words [2];
	logic cfg_mono [2];
	logic [31:0] fetch_log [$];
	sample_frame_t expect_q [$];

	tb_clock u_clock (.o_clock(i_clock), .o_reset(i_reset));

	audio_controller dut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Hashed fill; every fourth word sits near full scale
	function automatic logic [31:0] mem_data(input logic [31:0] addr);
		logic [31:0] h;
		h = addr * 32'h9e37_79b1;
		h = h ^ (h >> 16);
		return (addr[3:2] == 2'b11) ? {4'h7, h[27:16], 4'h8, h[11:0]} : h;
	endfunction

	function automatic int frames_of(input int ch);
		return cfg_mono[ch] ? 2 * cfg_words[ch] : cfg_words[ch];
	endfunction

	function automatic sample_frame_t channel_frame(input int ch, input int index);
		logic [31:0] word;
		sample_frame_t frame;
		word = mem_data(BASE[ch] + 32'(4 * (cfg_mono[ch] ? index / 2 : index)));
		// Left in the high half; mono plays the low half first
		frame.left = cfg_mono[ch] ? word[16 * (index % 2) +: 16] : word[31:16];
		frame.right = cfg_mono[ch] ? frame.left : word[15:0];
		return frame;
	endfunction

	function automatic int clamp16(input int value);
		return (value > 32767) ? 32767 : (value < -32768) ? -32768 : value;
	endfunction

	function automatic sample_frame_t expected_mix(input int t);
		int sum_left;
		int sum_right;
		sample_frame_t frame;
		sum_left = 0;
		sum_right = 0;
		for (int ch = 0; ch < 2; ch++) begin
			// An exhausted channel adds nothing
			if (t < frames_of(ch)) begin
				frame = channel_frame(ch, t);
				sum_left += int'(frame.left);
				sum_right += int'(frame.right);
			end
		end
		frame.left = 16'(clamp16(sum_left));
		frame.right = 16'(clamp16(sum_right));
		return frame;
	endfunction

	function automatic int fetched_words(input int ch, input int from);
		int n;
		n = 0;
		for (int i = from; i < fetch_log.size(); i++) begin
			if ((fetch_log[i] >= BASE[1]) == (ch == 1)) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input longint expected, input longint actual);
		stop_run($sformatf("FAIL at %0t: %s expected %0d got %0d", $time, name, expected, actual));
	endtask

	task automatic cpu_access(input logic write, input logic [3:0] addr, input logic [31:0] data,
			output logic [31:0] result);
		int waited;
		waited = 0;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= write;
		i_address <= addr;
		i_wdata <= data;
		@(posedge i_clock);
		while (!o_ready) begin
			waited++;
			assert (waited < 20) else stop_run("CPU access never got ready from the DUT");
			@(posedge i_clock);
		end
		result = o_rdata;
		i_request <= 1'b0;
	endtask

	task automatic send_ticks(input int first, input int last);
		for (int t = first; t < last; t++) begin
			@(posedge i_clock);
			i_sample_tick <= 1'b1;
			expect_q.push_back(expected_mix(t));
			@(posedge i_clock);
			i_sample_tick <= 1'b0;
			repeat (TICK_PERIOD - 2) @(posedge i_clock);
		end
	endtask

	task automatic play_streams(input int words0, input logic mono0, input int words1,
			input logic mono1, input int pause_after);
		logic [31:0] result;
		logic [1:0] started;
		int log_start;
		int ticks;
		int popped;
		int ahead;
		int seen [2];
		int ch;
		cfg_words = '{words0, words1};
		cfg_mono = '{mono0, mono1};
		started = {words1 > 0, words0 > 0};
		ticks = (frames_of(0) > frames_of(1)) ? frames_of(0) : frames_of(1);
		log_start = fetch_log.size();
		for (int c = 0; c < 2; c++) begin
			if (cfg_words[c] > 0) begin
				cpu_access(1'b1, (c == 0) ? REG_CH0_ADDR : REG_CH1_ADDR, BASE[c], result);
				cpu_access(1'b1, (c == 0) ? REG_CH0_COUNT : REG_CH1_COUNT,
					{cfg_mono[c], 31'(cfg_words[c])}, result);
			end
		end
		cpu_access(1'b0, REG_STATUS, '0, result);
		assert (result == 32'(started)) else report_mismatch("o_rdata status", started, result);
		repeat (60) @(posedge i_clock);
		if (pause_after > 0) begin
			send_ticks(0, pause_after);
			repeat (300) @(posedge i_clock);
			for (int c = 0; c < 2; c++) begin
				popped = (pause_after < frames_of(c)) ? pause_after : frames_of(c);
				ahead = fetched_words(c, log_start) - (cfg_mono[c] ? (popped + 1) / 2 : popped);
				assert (ahead <= FRAME_CREDITS + 1)
				else stop_run($sformatf("Channel %0d kept fetching in the pause, %0d words ahead",
					c, ahead));
			end
			send_ticks(pause_after, ticks);
		end else begin
			send_ticks(0, ticks);
		end
		repeat (10) @(posedge i_clock);
		cpu_access(1'b0, REG_STATUS, '0, result);
		assert (result == 32'd0) else report_mismatch("o_rdata status", 0, result);
		// Each channel's fetches must walk its buffer word by word
		seen = '{0, 0};
		for (int i = log_start; i < fetch_log.size(); i++) begin
			ch = (fetch_log[i] >= BASE[1]) ? 1 : 0;
			assert (fetch_log[i] == BASE[ch] + 32'(4 * seen[ch]))
			else report_mismatch("o_dma_address", BASE[ch] + 32'(4 * seen[ch]), fetch_log[i]);
			seen[ch]++;
		end
		for (int c = 0; c < 2; c++) begin
			assert (seen[c] == cfg_words[c])
			else report_mismatch($sformatf("channel %0d transfers", c), cfg_words[c], seen[c]);
		end
	endtask

	// DMA memory with a random response delay
	initial begin
		int delay;
		logic [31:0] rng;
		rng = xorshift(32'h61c2);
		delay = int'(rng % 32'd7);
		i_dma_ready = 1'b0;
		i_dma_rdata = '0;
		forever begin
			@(posedge i_clock);
			if (i_dma_ready) begin
				i_dma_ready <= 1'b0;
			end else if (o_dma_request) begin
				if (delay == 0) begin
					i_dma_ready <= 1'b1;
					i_dma_rdata <= mem_data(o_dma_address);
					fetch_log.push_back(o_dma_address);
					rng = xorshift(rng);
					delay = int'(rng % 32'd7);
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

	// Output check one cycle after each tick
	initial begin
		logic tick_seen;
		sample_frame_t want;
		tick_seen = 1'b0;
		forever begin
			@(posedge i_clock);
			if (tick_seen) begin
				assert (expect_q.size() > 0) else stop_run("Output sample with no tick queued");
				want = expect_q.pop_front();
				assert (o_left == want.left) else report_mismatch("o_left", want.left, o_left);
				assert (o_right == want.right) else report_mismatch("o_right", want.right, o_right);
			end
			tick_seen = i_sample_tick;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		stop_run("Timeout: the run did not finish within the watchdog limit");
	end

	initial begin
		logic [31:0] result;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_sample_tick = 1'b0;
		wait (!i_reset);
		cpu_access(1'b0, REG_RATE, '0, result);
		assert (result == DEFAULT_RATE_DIV)
		else report_mismatch("o_rdata rate", DEFAULT_RATE_DIV, result);
		cpu_access(1'b0, REG_STATUS, '0, result);
		assert (result == 32'd0) else report_mismatch("o_rdata status", 0, result);
		cpu_access(1'b1, REG_RATE, 32'd34, result);
		cpu_access(1'b0, REG_RATE, '0, result);
		assert (result == 32'd34) else report_mismatch("o_rdata rate", 34, result);
		assert (o_sample_rate == 32'd34) else report_mismatch("o_sample_rate", 34, o_sample_rate);
		// Stereo alone, mono alone, then both mixed with a pause in the ticks
		play_streams(6, 1'b0, 0, 1'b0, 0);
		play_streams(0, 1'b0, 4, 1'b1, 0);
		play_streams(12, 1'b0, 8, 1'b1, 5);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_reset
);

	// 10 ns period
	initial begin
		o_clock = 1'b0;
		forever #5 o_clock = ~o_clock;
	end

	// Reset held over the first 16 rising edges
	initial begin
		o_reset = 1'b1;
		repeat (16) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule
